// ==== common/rrag_consts.svh ====
`ifndef RRAG_CONSTS_SVH
`define RRAG_CONSTS_SVH

// queue depth, also decode's starting credit count
`define UOP_Q_DEPTH 8
// pointer and occupancy widths for the queue
`define UOP_PTR_WIDTH 3
`define UOP_CNT_WIDTH 4

// branch tag carried by every micro-op
`define UOP_TAG_WIDTH 3
// modifiable part: valid bit on top of the tag
`define UOP_M_WIDTH 4

// fixed payload fields
`define UOP_OP_WIDTH 4
`define UOP_EIP_WIDTH 32
`define UOP_IMM_WIDTH 16
// opcode + eip + immediate
`define UOP_N_WIDTH 52

// rrag side credits after reset
`define RRAG_CREDITS 4
`define RRAG_CRED_WIDTH 3

`endif

// ==== common/rrag_pkg.sv ====
package rrag_pkg;

    // micro-op opcodes as decode hands them over
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_AND    = 4'd2,
        OP_OR     = 4'd3,
        OP_SHIFT  = 4'd4,
        OP_LOAD   = 4'd5,
        OP_STORE  = 4'd6,
        OP_BRANCH = 4'd7
    } uop_op_e;

    // what the issue stage does with the head this cycle
    typedef enum logic [1:0] {
        // nothing to pop, or no rrag credit
        ISSUE_IDLE = 2'd0,
        // head was squashed, pop it quietly
        ISSUE_DROP = 2'd1,
        // head is live, pop and send to rrag
        ISSUE_SEND = 2'd2
    } issue_state_e;

endpackage

// ==== queue/uop_queue.sv ====
`include "rrag_consts.svh"

module uop_queue
    import rrag_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   arst_n,
    // decode write side
    input  logic                                   wr,
    input  logic [`UOP_TAG_WIDTH-1:0]              in_tag,
    input  uop_op_e                                in_op,
    input  logic [`UOP_EIP_WIDTH-1:0]              in_eip,
    input  logic [`UOP_IMM_WIDTH-1:0]              in_imm,
    // issue side
    input  logic                                   pop,
    // in-place modify port
    input  logic [`UOP_Q_DEPTH-1:0]                modify_vector,
    input  logic [`UOP_M_WIDTH*`UOP_Q_DEPTH-1:0]   new_m_vector,
    output logic [`UOP_M_WIDTH*`UOP_Q_DEPTH-1:0]   old_m_vector,
    // head entry
    output logic [`UOP_M_WIDTH-1:0]                head_m,
    output uop_op_e                                head_op,
    output logic [`UOP_EIP_WIDTH-1:0]              head_eip,
    output logic [`UOP_IMM_WIDTH-1:0]              head_imm,
    // status and credit return
    output logic                                   empty,
    output logic                                   full,
    output logic                                   in_credit
);

    // modifiable fields, {valid, tag} per entry
    logic [`UOP_M_WIDTH-1:0] m_mem [`UOP_Q_DEPTH];
    // fixed fields, {op, eip, imm} per entry
    logic [`UOP_N_WIDTH-1:0] n_mem [`UOP_Q_DEPTH];

    logic [`UOP_PTR_WIDTH-1:0] wr_ptr;
    logic [`UOP_PTR_WIDTH-1:0] rd_ptr;
    logic [`UOP_CNT_WIDTH-1:0] count;

    logic                      do_wr;
    logic                      do_pop;
    logic [`UOP_N_WIDTH-1:0]   head_n;

    // circular pointer advance
    function automatic logic [`UOP_PTR_WIDTH-1:0] ptr_inc(
        input logic [`UOP_PTR_WIDTH-1:0] ptr
    );
        if (ptr == `UOP_PTR_WIDTH'(`UOP_Q_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == `UOP_CNT_WIDTH'(`UOP_Q_DEPTH));

    // ignore a write into a full queue or a pop from an empty one
    assign do_wr  = wr & ~full;
    assign do_pop = pop & ~empty;

    // pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // modifiable part
    // modify vector first, then the write at the tail
    // the tail slot is free, so a write never loses a stored entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `UOP_Q_DEPTH; i++) begin
                m_mem[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `UOP_Q_DEPTH; i++) begin
                if (modify_vector[i]) begin
                    m_mem[i] <= new_m_vector[i*`UOP_M_WIDTH +: `UOP_M_WIDTH];
                end
            end
            // new entry always starts valid
            if (do_wr) begin
                m_mem[wr_ptr] <= {1'b1, in_tag};
            end
        end
    end

    // fixed payload, written once and never modified
    always_ff @(posedge clk) begin
        if (do_wr) begin
            n_mem[wr_ptr] <= {in_op, in_eip, in_imm};
        end
    end

    // whole modifiable array for squash control
    always_comb begin
        for (int i = 0; i < `UOP_Q_DEPTH; i++) begin
            old_m_vector[i*`UOP_M_WIDTH +: `UOP_M_WIDTH] = m_mem[i];
        end
    end

    // head entry
    assign head_m   = m_mem[rd_ptr];
    assign head_n   = n_mem[rd_ptr];
    assign head_op  = uop_op_e'(head_n[`UOP_N_WIDTH-1 -: `UOP_OP_WIDTH]);
    assign head_eip = head_n[`UOP_IMM_WIDTH +: `UOP_EIP_WIDTH];
    assign head_imm = head_n[`UOP_IMM_WIDTH-1:0];

    // one credit back to decode per pop, one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= do_pop;
        end
    end

endmodule

// ==== logic/squash_ctrl.sv ====
`include "rrag_consts.svh"

module squash_ctrl (
    // squash request from the branch side
    input  logic                                   squash_valid,
    input  logic [`UOP_TAG_WIDTH-1:0]              squash_tag,
    // current modifiable fields of all entries
    input  logic [`UOP_M_WIDTH*`UOP_Q_DEPTH-1:0]   old_m_vector,
    // entries to rewrite, and what they become
    output logic [`UOP_Q_DEPTH-1:0]                modify_vector,
    output logic [`UOP_M_WIDTH*`UOP_Q_DEPTH-1:0]   new_m_vector
);

    // one compare per queue slot
    for (genvar i = 0; i < `UOP_Q_DEPTH; i++) begin : g_entry
        logic [`UOP_M_WIDTH-1:0]   old_m;
        logic                      old_valid;
        logic [`UOP_TAG_WIDTH-1:0] old_tag;
        logic                      tag_hit;

        // unpack {valid, tag}
        assign old_m     = old_m_vector[i*`UOP_M_WIDTH +: `UOP_M_WIDTH];
        assign old_valid = old_m[`UOP_M_WIDTH-1];
        assign old_tag   = old_m[`UOP_TAG_WIDTH-1:0];

        assign tag_hit = (old_tag == squash_tag);

        // only live entries with the squashed tag get rewritten
        assign modify_vector[i] = squash_valid & old_valid & tag_hit;

        // tag stays, valid bit drops
        // issue side sees the cleared bit and drops the entry
        assign new_m_vector[i*`UOP_M_WIDTH +: `UOP_M_WIDTH] = {1'b0, old_tag};
    end

endmodule

// ==== logic/issue_ctrl.sv ====
`include "rrag_consts.svh"

module issue_ctrl
    import rrag_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    // queue head
    input  logic                       empty,
    input  logic [`UOP_M_WIDTH-1:0]    head_m,
    input  uop_op_e                    head_op,
    input  logic [`UOP_EIP_WIDTH-1:0]  head_eip,
    input  logic [`UOP_IMM_WIDTH-1:0]  head_imm,
    // credit return pulse from rrag
    input  logic                       out_credit,
    // pop back to the queue
    output logic                       pop,
    // micro-op to rrag
    output logic                       out_valid,
    output uop_op_e                    out_op,
    output logic [`UOP_EIP_WIDTH-1:0]  out_eip,
    output logic [`UOP_IMM_WIDTH-1:0]  out_imm
);

    issue_state_e               state;
    logic [`RRAG_CRED_WIDTH-1:0] credits;
    logic                       head_valid;
    logic                       send;

    // valid bit sits above the tag
    assign head_valid = head_m[`UOP_M_WIDTH-1];

    // pick this cycle's action from the head and the credit count
    // squashed heads go regardless of credits, they cost rrag nothing
    always_comb begin
        if (empty) begin
            state = ISSUE_IDLE;
        end else if (!head_valid) begin
            state = ISSUE_DROP;
        end else if (credits != '0) begin
            state = ISSUE_SEND;
        end else begin
            // live head but rrag is full, wait in the queue
            state = ISSUE_IDLE;
        end
    end

    assign send = (state == ISSUE_SEND);
    // at most one pop per cycle, for a drop or a send
    assign pop  = (state == ISSUE_DROP) || send;

    // rrag credit counter
    // send and return in the same cycle cancel out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= `RRAG_CRED_WIDTH'(`RRAG_CREDITS);
        end else begin
            case ({send, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // out_valid one cycle after the pop edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
        end
    end

    // payload only loads on a send
    always_ff @(posedge clk) begin
        if (send) begin
            out_op  <= head_op;
            out_eip <= head_eip;
            out_imm <= head_imm;
        end
    end

endmodule

// ==== logic/decode_rrag_top.sv ====
`include "rrag_consts.svh"

module decode_rrag_top
    import rrag_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    // decode
    input  logic                       in_valid,
    input  logic [`UOP_TAG_WIDTH-1:0]  in_tag,
    input  uop_op_e                    in_op,
    input  logic [`UOP_EIP_WIDTH-1:0]  in_eip,
    input  logic [`UOP_IMM_WIDTH-1:0]  in_imm,
    output logic                       in_credit,
    // branch squash
    input  logic                       squash_valid,
    input  logic [`UOP_TAG_WIDTH-1:0]  squash_tag,
    // rrag
    input  logic                       out_credit,
    output logic                       out_valid,
    output uop_op_e                    out_op,
    output logic [`UOP_EIP_WIDTH-1:0]  out_eip,
    output logic [`UOP_IMM_WIDTH-1:0]  out_imm
);

    // queue <-> squash control
    logic [`UOP_M_WIDTH*`UOP_Q_DEPTH-1:0] old_m_vector;
    logic [`UOP_M_WIDTH*`UOP_Q_DEPTH-1:0] new_m_vector;
    logic [`UOP_Q_DEPTH-1:0]              modify_vector;

    // queue <-> issue control
    logic [`UOP_M_WIDTH-1:0]   head_m;
    uop_op_e                   head_op;
    logic [`UOP_EIP_WIDTH-1:0] head_eip;
    logic [`UOP_IMM_WIDTH-1:0] head_imm;
    logic                      empty;
    logic                      full;
    logic                      pop;

    uop_queue uop_queue_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .wr            (in_valid),
        .in_tag        (in_tag),
        .in_op         (in_op),
        .in_eip        (in_eip),
        .in_imm        (in_imm),
        .pop           (pop),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector),
        .old_m_vector  (old_m_vector),
        .head_m        (head_m),
        .head_op       (head_op),
        .head_eip      (head_eip),
        .head_imm      (head_imm),
        .empty         (empty),
        .full          (full),
        .in_credit     (in_credit)
    );

    squash_ctrl squash_ctrl_i (
        .squash_valid  (squash_valid),
        .squash_tag    (squash_tag),
        .old_m_vector  (old_m_vector),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector)
    );

    issue_ctrl issue_ctrl_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .empty      (empty),
        .head_m     (head_m),
        .head_op    (head_op),
        .head_eip   (head_eip),
        .head_imm   (head_imm),
        .out_credit (out_credit),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_op     (out_op),
        .out_eip    (out_eip),
        .out_imm    (out_imm)
    );

endmodule

// ==== sim/decode_rrag_checker.sv ====
`include "rrag_consts.svh"

module decode_rrag_checker (
    input logic clk,
    input logic arst_n,
    input logic in_valid,
    input logic full,
    input logic pop,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);

    // micro-ops sitting in rrag that have not returned a credit yet
    int outstanding;
    int full_fails = 0;
    int credit_fails = 0;
    int pop_fails = 0;
    int fails;

    assign fails = full_fails + credit_fails + pop_fails;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(out_valid) - int'(out_credit);
        end
    end

    // decode must run out of credits before the queue fills up
    no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        !(in_valid && full))
        else begin
            full_fails++;
            $error("decode wrote into a full queue");
        end

    // rrag never holds more than its credit pool
    rrag_credit_limit: assert property (@(posedge clk) disable iff (!arst_n)
        outstanding <= `RRAG_CREDITS)
        else begin
            credit_fails++;
            $error("more micro-ops in rrag than rrag credits");
        end

    // one decode credit for every pop, one cycle later
    credit_per_pop: assert property (@(posedge clk) disable iff (!arst_n)
        in_credit == $past(pop))
        else begin
            pop_fails++;
            $error("in_credit does not follow pop by one cycle");
        end

endmodule

bind decode_rrag_top decode_rrag_checker checker_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .full       (full),
    .pop        (pop),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_credit (out_credit)
);

// ==== sim/decode_rrag_monitor.sv ====
`include "rrag_consts.svh"

module decode_rrag_monitor
    import rrag_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_valid,
    input  logic [`UOP_TAG_WIDTH-1:0]  in_tag,
    input  uop_op_e                    in_op,
    input  logic [`UOP_EIP_WIDTH-1:0]  in_eip,
    input  logic [`UOP_IMM_WIDTH-1:0]  in_imm,
    input  logic                       squash_valid,
    input  logic [`UOP_TAG_WIDTH-1:0]  squash_tag,
    input  logic                       in_credit,
    input  logic                       out_credit,
    input  logic                       out_valid,
    input  uop_op_e                    out_op,
    input  logic [`UOP_EIP_WIDTH-1:0]  out_eip,
    input  logic [`UOP_IMM_WIDTH-1:0]  out_imm,
    output int                         errors,
    output int                         sends,
    output int                         live
);

    // model queue, oldest first
    logic [`UOP_N_WIDTH-1:0]   m_payload [$];
    logic [`UOP_TAG_WIDTH-1:0] m_tag [$];
    bit                        m_valid [$];

    // decode and squash seen at the previous edge
    // applied one edge late, so a send decided at that edge still sees its entry
    logic                      wr_d;
    logic                      sq_d;
    logic [`UOP_TAG_WIDTH-1:0] wr_tag_d;
    logic [`UOP_TAG_WIDTH-1:0] sq_tag_d;
    logic [`UOP_N_WIDTH-1:0]   wr_payload_d;
    int                        returns;
    int                        returns_lag;
    bit                        seen_write;

    always @(posedge clk) begin
        if (!arst_n) begin
            errors = 0;
            sends = 0;
            live = 0;
            returns = 0;
            returns_lag = 0;
            wr_d = 1'b0;
            sq_d = 1'b0;
            seen_write = 1'b0;
            m_payload.delete();
            m_tag.delete();
            m_valid.delete();
        end else begin
            // nothing leaves the queue before decode writes
            if (!seen_write && (out_valid || in_credit)) begin
                errors++;
                $display("mismatch reset_quiet: expected %b actual %b", 2'b00,
                         {out_valid, in_credit});
            end
            if (out_valid) begin
                sends++;
                // send at the last edge could only use returns up to the edge before
                if (sends > `RRAG_CREDITS + returns_lag) begin
                    errors++;
                    $display("mismatch credit_limit: expected at most %0d actual %0d",
                             `RRAG_CREDITS + returns_lag, sends);
                end
                // squashed entries ahead of it were dropped silently
                while (m_valid.size() > 0 && !m_valid[0]) begin
                    void'(m_payload.pop_front());
                    void'(m_tag.pop_front());
                    void'(m_valid.pop_front());
                end
                if (m_valid.size() == 0) begin
                    errors++;
                    $display("out_valid came while no live micro-op was waiting");
                end else begin
                    if ({out_op, out_eip, out_imm} !== m_payload[0]) begin
                        errors++;
                        $display("mismatch issue_order: expected %h actual %h",
                                 m_payload[0], {out_op, out_eip, out_imm});
                    end
                    void'(m_payload.pop_front());
                    void'(m_tag.pop_front());
                    void'(m_valid.pop_front());
                end
            end
            returns_lag = returns;
            if (out_credit) begin
                returns++;
            end
            // squash hits only what was stored before its edge
            if (sq_d) begin
                foreach (m_tag[i]) begin
                    if (m_tag[i] == sq_tag_d) begin
                        m_valid[i] = 1'b0;
                    end
                end
            end
            if (wr_d) begin
                m_payload.push_back(wr_payload_d);
                m_tag.push_back(wr_tag_d);
                m_valid.push_back(1'b1);
            end
            wr_d = in_valid;
            wr_tag_d = in_tag;
            wr_payload_d = {in_op, in_eip, in_imm};
            sq_d = squash_valid;
            sq_tag_d = squash_tag;
            if (in_valid) begin
                seen_write = 1'b1;
            end
            live = 0;
            foreach (m_valid[i]) begin
                if (m_valid[i]) begin
                    live++;
                end
            end
        end
    end

endmodule

// ==== sim/tb_decode_rrag.sv ====
`include "rrag_consts.svh"

module tb_decode_rrag
    import rrag_pkg::*;
();

    // row kinds of the stimulus table
    localparam int row_write = 0;
    localparam int row_squash = 1;
    localparam int row_wr_squash = 2;
    localparam int row_idle = 3;
    localparam int row_hold = 4;
    localparam int row_release = 5;
    localparam int wait_limit = 400;

    typedef struct {
        int                        kind;
        logic [`UOP_TAG_WIDTH-1:0] tag;
        uop_op_e                   op;
        logic [`UOP_EIP_WIDTH-1:0] eip;
        logic [`UOP_IMM_WIDTH-1:0] imm;
        logic [`UOP_TAG_WIDTH-1:0] sq_tag;
        int                        n;
        // write must come out at rrag
        bit                        expect_issue;
    } row_t;

    logic                      clk = 1'b0;
    logic                      arst_n;
    logic                      in_valid;
    logic [`UOP_TAG_WIDTH-1:0] in_tag;
    uop_op_e                   in_op;
    logic [`UOP_EIP_WIDTH-1:0] in_eip;
    logic [`UOP_IMM_WIDTH-1:0] in_imm;
    logic                      in_credit;
    logic                      squash_valid;
    logic [`UOP_TAG_WIDTH-1:0] squash_tag;
    logic                      out_credit = 1'b0;
    logic                      out_valid;
    uop_op_e                   out_op;
    logic [`UOP_EIP_WIDTH-1:0] out_eip;
    logic [`UOP_IMM_WIDTH-1:0] out_imm;

    row_t rows[$];
    int   writes = 0;
    int   credits_back = 0;
    int   expected_sends = 0;
    int   tb_errors = 0;
    int   mon_errors;
    int   mon_sends;
    int   mon_live;
    // rrag keeps its credits while hold is set
    bit   hold = 1'b0;
    int   rrag_due[$];
    int   cycle = 0;

    always #2 clk = ~clk;

    decode_rrag_top decode_rrag_top_i (
        .clk (clk), .arst_n (arst_n),
        .in_valid (in_valid), .in_tag (in_tag), .in_op (in_op),
        .in_eip (in_eip), .in_imm (in_imm), .in_credit (in_credit),
        .squash_valid (squash_valid), .squash_tag (squash_tag),
        .out_credit (out_credit), .out_valid (out_valid), .out_op (out_op),
        .out_eip (out_eip), .out_imm (out_imm)
    );

    decode_rrag_monitor monitor_i (
        .clk (clk), .arst_n (arst_n),
        .in_valid (in_valid), .in_tag (in_tag), .in_op (in_op),
        .in_eip (in_eip), .in_imm (in_imm),
        .squash_valid (squash_valid), .squash_tag (squash_tag),
        .in_credit (in_credit), .out_credit (out_credit), .out_valid (out_valid),
        .out_op (out_op), .out_eip (out_eip), .out_imm (out_imm),
        .errors (mon_errors), .sends (mon_sends), .live (mon_live)
    );

    // decode side credit returns
    always @(posedge clk) begin
        if (in_credit) begin
            credits_back <= credits_back + 1;
        end
    end

    // rrag, each micro-op gives its credit back 0 to 3 cycles later
    // at most one return per cycle, later ones queue up
    always @(negedge clk) begin
        cycle = cycle + 1;
        out_credit = 1'b0;
        if (out_valid) begin
            rrag_due.push_back(cycle + int'($urandom_range(3)));
        end
        if (!hold && rrag_due.size() > 0 && rrag_due[0] <= cycle) begin
            void'(rrag_due.pop_front());
            out_credit = 1'b1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic add_row(input int kind, input int tag, input uop_op_e op, input int eip,
                           input int imm, input int sq_tag, input int n, input bit exp);
        row_t r;
        r.kind = kind;
        r.tag = `UOP_TAG_WIDTH'(tag);
        r.op = op;
        r.eip = eip;
        r.imm = `UOP_IMM_WIDTH'(imm);
        r.sq_tag = `UOP_TAG_WIDTH'(sq_tag);
        r.n = n;
        r.expect_issue = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        uop_op_e op;
        // quiet outputs right after reset
        add_row(row_idle, 0, OP_ADD, 0, 0, 0, 3, 1'b0);
        // rrag holds its credits, four tag 0 ops use them all up
        add_row(row_hold, 0, OP_ADD, 0, 0, 0, 0, 1'b0);
        add_row(row_write, 0, OP_ADD, 'h1000, 'h11, 0, 0, 1'b1);
        add_row(row_write, 0, OP_SUB, 'h1004, 'h22, 0, 0, 1'b1);
        add_row(row_write, 0, OP_AND, 'h1008, 'h33, 0, 0, 1'b1);
        add_row(row_write, 0, OP_OR, 'h100c, 'h44, 0, 0, 1'b1);
        // these stay stuck behind the empty credit pool
        add_row(row_write, 1, OP_LOAD, 'h2000, 'h55, 0, 0, 1'b0);
        add_row(row_write, 2, OP_STORE, 'h2004, 'h66, 0, 0, 1'b1);
        add_row(row_write, 1, OP_SHIFT, 'h2008, 'h77, 0, 0, 1'b0);
        add_row(row_write, 3, OP_BRANCH, 'h200c, 'h88, 0, 0, 1'b1);
        add_row(row_idle, 0, OP_ADD, 0, 0, 0, 4, 1'b0);
        // squash tag 1, the tag 1 write in the same cycle survives
        add_row(row_wr_squash, 1, OP_ADD, 'h2010, 'h99, 1, 0, 1'b1);
        add_row(row_idle, 0, OP_ADD, 0, 0, 0, 2, 1'b0);
        add_row(row_release, 0, OP_ADD, 0, 0, 0, 0, 1'b0);
        // random traffic on tags 4 to 7, squashes of the long gone tag 0
        for (int i = 0; i < 16; i++) begin
            op = uop_op_e'(`UOP_OP_WIDTH'($urandom_range(7)));
            add_row(row_write, int'($urandom_range(7, 4)), op, int'($urandom()),
                    int'($urandom()), 0, 0, 1'b1);
            if (i % 4 == 3) begin
                add_row(row_squash, 0, OP_ADD, 0, 0, 0, 0, 1'b0);
            end
            add_row(row_idle, 0, OP_ADD, 0, 0, 0, int'($urandom_range(2)), 1'b0);
        end
    endtask

    // decode holds a credit per free queue slot
    task automatic wait_credit();
        int waited;
        waited = 0;
        while (`UOP_Q_DEPTH - writes + credits_back <= 0) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout while decode waited for a credit");
            end
        end
    endtask

    task automatic apply_row(input row_t r);
        case (r.kind)
            row_idle: repeat (r.n) @(negedge clk);
            row_hold: hold = 1'b1;
            row_release: hold = 1'b0;
            default: begin
                if (r.kind != row_squash) begin
                    wait_credit();
                end
                in_valid = (r.kind != row_squash);
                in_tag = r.tag;
                in_op = r.op;
                in_eip = r.eip;
                in_imm = r.imm;
                squash_valid = (r.kind != row_write);
                squash_tag = r.sq_tag;
                if (in_valid) begin
                    writes++;
                end
                @(negedge clk);
                in_valid = 1'b0;
                squash_valid = 1'b0;
            end
        endcase
    endtask

    initial begin
        int waited;
        int chk_fails;
        void'($urandom(43));
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_tag = '0;
        in_op = OP_ADD;
        in_eip = '0;
        in_imm = '0;
        squash_valid = 1'b0;
        squash_tag = '0;
        build_table();
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        foreach (rows[i]) begin
            if (rows[i].expect_issue) begin
                expected_sends++;
            end
            apply_row(rows[i]);
        end

        // drained once decode holds every credit again
        waited = 0;
        while (`UOP_Q_DEPTH - writes + credits_back != `UOP_Q_DEPTH) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) begin
                abort_run("timeout while the queue drained");
            end
        end
        repeat (2) @(negedge clk);

        if (mon_sends != expected_sends) begin
            tb_errors++;
            $display("mismatch issue_count: expected %0d actual %0d", expected_sends, mon_sends);
        end
        if (mon_live != 0) begin
            tb_errors++;
            $display("%0d live micro-ops never reached rrag", mon_live);
        end
        chk_fails = decode_rrag_top_i.checker_i.fails;
        $display("errors: monitor %0d, testbench %0d, assertions %0d",
                 mon_errors, tb_errors, chk_fails);
        if (mon_errors + tb_errors + chk_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+common
common/rrag_pkg.sv
queue/uop_queue.sv
logic/squash_ctrl.sv
logic/issue_ctrl.sv
logic/decode_rrag_top.sv
sim/decode_rrag_checker.sv
sim/decode_rrag_monitor.sv
sim/tb_decode_rrag.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode to rrag testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f files.f \
    --top-module tb_decode_rrag -o tb_decode_rrag
./obj_dir/tb_decode_rrag +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Done: no errors" sim.log; then
    exit 0
fi
exit 1
